// ==== Makefile ====
# Verilator build and run of the host I/O bridge testbench
TOP := tb_hps_io

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+sim
hdl/hps_pkg.sv
hdl/io_frame.sv
hdl/host_regs.sv
hdl/file_loader.sv
hdl/kbd_link.sv
hdl/hps_io.sv
sim/tb_hps_io.sv

// ==== hdl/file_loader.sv ====
////////////////////////////////////////
// file download handler
// index, extension, start/end and the data write stream
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module file_loader #(
	parameter bit wide = 1'b0
) (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  hps_pkg::hps_frame_t frame,
	output hps_pkg::ioctl_t     ioctl
);

	localparam logic [26:0] addr_step = wide ? 27'd2 : 27'd1;

	logic        download_q;
	logic        wr_pend;
	logic        wr_q;
	logic [26:0] addr_cnt;
	logic [26:0] addr_q;
	logic [7:0]  index_q;
	logic [15:0] dout_q;
	logic [31:0] ext_q;
	logic        data_word;
	logic        tx_word;
	logic        dat_word;

	assign data_word = frame.strobe && !frame.first;
	assign tx_word   = data_word && frame.cmd == hps_pkg::cmd_file_tx;
	assign dat_word  = data_word && frame.cmd == hps_pkg::cmd_file_tx_dat;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			download_q <= 1'b0;
			wr_pend    <= 1'b0;
			wr_q       <= 1'b0;
			addr_cnt   <= '0;
		end else begin
			// write strobe trails address and data by one cycle
			wr_pend <= dat_word;
			wr_q    <= wr_pend;
			if (tx_word) begin
				download_q <= (frame.data[7:0] != 8'h00);
				if (frame.data[7:0] != 8'h00)
					addr_cnt <= '0;
			end
			if (dat_word)
				addr_cnt <= addr_cnt + addr_step;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_word && frame.cmd == hps_pkg::cmd_file_index)
			index_q <= frame.data[7:0];
		if (data_word && frame.cmd == hps_pkg::cmd_file_info) begin
			// extension arrives high half first
			if (frame.idx == 10'd1)
				ext_q[31:16] <= frame.data;
			if (frame.idx == 10'd2)
				ext_q[15:0] <= frame.data;
		end
		// end word leaves the final count on the address
		if (tx_word && frame.data[7:0] == 8'h00)
			addr_q <= addr_cnt;
		if (dat_word) begin
			addr_q <= addr_cnt;
			dout_q <= wide ? frame.data : {8'h00, frame.data[7:0]};
		end
	end

	assign ioctl.download = download_q;
	assign ioctl.index    = index_q;
	assign ioctl.wr       = wr_q;
	assign ioctl.addr     = addr_q;
	assign ioctl.dout     = dout_q;
	assign ioctl.file_ext = ext_q;

endmodule

`default_nettype wire

// ==== hdl/host_regs.sv ====
////////////////////////////////////////
// core register handler
// config byte, joysticks, status word and config string readback
// owns the response word back to the host
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module host_regs #(
	parameter int str_len = 1
) (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  hps_pkg::hps_frame_t   frame,
	input  wire [8*str_len-1:0]   conf_str,
	input  wire [63:0]            status_in,
	input  wire                   status_set,
	output logic [15:0]           io_dout,
	output logic [7:0]            cfg,
	output hps_pkg::joy_bank_t    joystick,
	output logic [63:0]           status
);

	logic        set_q;
	logic [3:0]  req_cnt;
	logic [63:0] status_req;
	logic        joy_hit;
	logic [2:0]  joy_sel;
	logic [7:0]  str_byte;

	// joystick slot for the current command
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (frame.cmd)
			hps_pkg::cmd_joy0: joy_sel = 3'd0;
			hps_pkg::cmd_joy1: joy_sel = 3'd1;
			hps_pkg::cmd_joy2: joy_sel = 3'd2;
			hps_pkg::cmd_joy3: joy_sel = 3'd3;
			hps_pkg::cmd_joy4: joy_sel = 3'd4;
			hps_pkg::cmd_joy5: joy_sel = 3'd5;
			default: joy_hit = 1'b0;
		endcase
	end

	// word k returns byte k-1 counted from the top of the string
	always_comb begin
		str_byte = 8'h00;
		for (int i = 0; i < str_len; i++) begin
			if (frame.idx == 10'(i + 1))
				str_byte = conf_str[(str_len - 1 - i) * 8 +: 8];
		end
	end

	////////////////////////////////////////
	// status set requests from the core
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			set_q   <= 1'b0;
			req_cnt <= '0;
		end else begin
			set_q <= status_set;
			if (status_set && !set_q)
				req_cnt <= req_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !set_q)
			status_req <= status_in;
	end

	////////////////////////////////////////
	// command words
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout  <= '0;
			cfg      <= '0;
			joystick <= '0;
			status   <= '0;
		end else if (!frame.active) begin
			io_dout <= '0;
		end else if (frame.strobe) begin
			io_dout <= '0;
			if (frame.first) begin
				if (frame.cmd == hps_pkg::cmd_status_get)
					io_dout <= {8'h00, 4'hA, req_cnt};
			end else begin
				if (frame.cmd == hps_pkg::cmd_cfg)
					cfg <= frame.data[7:0];
				if (joy_hit && frame.idx == 10'd1)
					joystick[joy_sel][15:0] <= frame.data;
				if (joy_hit && frame.idx == 10'd2)
					joystick[joy_sel][31:16] <= frame.data;
				if (frame.cmd == hps_pkg::cmd_status) begin
					case (frame.idx)
						10'd1: status[15:0]  <= frame.data;
						10'd2: status[31:16] <= frame.data;
						10'd3: status[47:32] <= frame.data;
						10'd4: status[63:48] <= frame.data;
						default: ;
					endcase
				end
				if (frame.cmd == hps_pkg::cmd_status_get) begin
					case (frame.idx)
						10'd1: io_dout <= status_req[15:0];
						10'd2: io_dout <= status_req[31:16];
						10'd3: io_dout <= status_req[47:32];
						10'd4: io_dout <= status_req[63:48];
						default: ;
					endcase
				end
				if (frame.cmd == hps_pkg::cmd_conf_str)
					io_dout <= {8'h00, str_byte};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/hps_io.sv ====
////////////////////////////////////////
// host I/O bridge top level
// frame tracker feeding the register, download and keyboard handlers
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hps_io #(
	parameter int str_len   = 1,
	parameter bit wide      = 1'b0,
	parameter int ps2_div   = 3,
	parameter int fifo_bits = 4
) (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  hps_pkg::hps_bus_in_t host_in,
	input  wire                  ioctl_wait,
	input  wire [8*str_len-1:0]  conf_str,
	input  wire [63:0]           status_in,
	input  wire                  status_set,
	output logic [15:0]          io_dout,
	output logic                 io_wait,
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output hps_pkg::joy_bank_t   joystick,
	output logic [63:0]          status,
	output hps_pkg::ioctl_t      ioctl,
	output hps_pkg::ps2_key_t    ps2_key,
	output logic                 ps2_kbd_clk,
	output logic                 ps2_kbd_data
);

	hps_pkg::hps_frame_t frame;
	logic [7:0]          cfg;

	// the core's wait is the only back-pressure toward the host
	assign io_wait = ioctl_wait;

	// cfg bits 2, 3 and 5 are handled outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	io_frame u_frame (
		.clk_sys (clk_sys),
		.reset   (reset),
		.host_in (host_in),
		.frame   (frame)
	);

	host_regs #(.str_len(str_len)) u_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.frame      (frame),
		.conf_str   (conf_str),
		.status_in  (status_in),
		.status_set (status_set),
		.io_dout    (io_dout),
		.cfg        (cfg),
		.joystick   (joystick),
		.status     (status)
	);

	file_loader #(.wide(wide)) u_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.frame   (frame),
		.ioctl   (ioctl)
	);

	kbd_link #(.ps2_div(ps2_div), .fifo_bits(fifo_bits)) u_kbd (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.frame        (frame),
		.ps2_key      (ps2_key),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data)
	);

endmodule

`default_nettype wire

// ==== hdl/hps_pkg.sv ====
////////////////////////////////////////
// host bridge shared definitions
// command codes, bus and frame structs, download and key event types
////////////////////////////////////////
`default_nettype none

package hps_pkg;

	// command codes sent as the first word of a frame
	localparam logic [15:0] cmd_cfg        = 16'h0001;
	localparam logic [15:0] cmd_joy0       = 16'h0002;
	localparam logic [15:0] cmd_joy1       = 16'h0003;
	localparam logic [15:0] cmd_kbd        = 16'h0005;
	localparam logic [15:0] cmd_joy2       = 16'h0010;
	localparam logic [15:0] cmd_joy3       = 16'h0011;
	localparam logic [15:0] cmd_joy4       = 16'h0012;
	localparam logic [15:0] cmd_joy5       = 16'h0013;
	localparam logic [15:0] cmd_conf_str   = 16'h0014;
	localparam logic [15:0] cmd_status     = 16'h001E;
	localparam logic [15:0] cmd_status_get = 16'h0029;
	localparam logic [15:0] cmd_file_tx     = 16'h0053;
	localparam logic [15:0] cmd_file_tx_dat = 16'h0054;
	localparam logic [15:0] cmd_file_index  = 16'h0055;
	localparam logic [15:0] cmd_file_info   = 16'h0056;

	// upper byte of a keyboard word that marks the rest of the frame as skipped
	localparam logic [7:0] kbd_skip_mark = 8'hFF;

	typedef struct packed {
		logic        enable;
		logic        strobe;
		logic [15:0] din;
	} hps_bus_in_t;

	// broadcast to every command handler
	typedef struct packed {
		logic        active;
		logic        strobe;
		logic        first;
		logic [15:0] cmd;
		logic [9:0]  idx;
		logic [15:0] data;
		logic        done;
	} hps_frame_t;

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [26:0] addr;
		logic [15:0] dout;
		logic [31:0] file_ext;
	} ioctl_t;

	// same bit layout as the legacy 11-bit key port
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	typedef logic [5:0][31:0] joy_bank_t;

endpackage

`default_nettype wire

// ==== hdl/io_frame.sv ====
////////////////////////////////////////
// host bus frame tracker
// latches the command word and counts words, then broadcasts them
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module io_frame (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  hps_pkg::hps_bus_in_t host_in,
	output hps_pkg::hps_frame_t  frame
);

	logic [15:0] cmd_q;
	logic [9:0]  idx_q;
	logic        enable_q;
	logic        word;

	assign word = host_in.enable && host_in.strobe;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd_q    <= '0;
			idx_q    <= '0;
			enable_q <= 1'b0;
		end else begin
			enable_q <= host_in.enable;
			if (!host_in.enable) begin
				cmd_q <= '0;
				idx_q <= '0;
			end else if (word) begin
				if (idx_q == '0)
					cmd_q <= host_in.din;
				// counter sticks at its top value on long frames
				if (idx_q != '1)
					idx_q <= idx_q + 10'd1;
			end
		end
	end

	// handlers see the command already on the command word itself
	assign frame.active = host_in.enable;
	assign frame.strobe = word;
	assign frame.first  = word && (idx_q == '0);
	assign frame.cmd    = (idx_q == '0) ? host_in.din : cmd_q;
	assign frame.idx    = idx_q;
	assign frame.data   = host_in.din;
	// cmd_q still holds the closed frame's command during this pulse
	assign frame.done   = enable_q && !host_in.enable;

endmodule

`default_nettype wire

// ==== hdl/kbd_link.sv ====
////////////////////////////////////////
// keyboard link
// decodes scan bytes into key events and replays them
// as PS/2 device frames through a byte FIFO
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module kbd_link #(
	parameter int ps2_div   = 3,
	parameter int fifo_bits = 4
) (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  hps_pkg::hps_frame_t frame,
	output hps_pkg::ps2_key_t   ps2_key,
	output logic                ps2_kbd_clk,
	output logic                ps2_kbd_data
);

	localparam int div_w = (ps2_div > 0) ? $clog2(ps2_div + 1) : 1;

	logic                 kbd_word;
	logic                 skip;
	logic [31:0]          raw;
	logic                 pressed;
	logic                 extended;
	logic [7:0]           fifo_mem [2**fifo_bits];
	logic [fifo_bits-1:0] wptr;
	logic [fifo_bits-1:0] rptr;
	logic [div_w-1:0]     div_cnt;
	logic                 bit_clk;
	logic                 tick;
	logic                 rise;
	logic                 fall;
	logic [3:0]           tx_state;
	logic [7:0]           tx_byte;
	logic                 parity;
	logic [1:0]           idle_cnt;

	assign kbd_word = frame.strobe && !frame.first && frame.cmd == hps_pkg::cmd_kbd;

	////////////////////////////////////////
	// key event decode
	////////////////////////////////////////

	// for a release the prefix sits in front of the f0
	assign pressed  = raw[15:8] != 8'hF0;
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			skip    <= 1'b0;
			raw     <= '0;
			ps2_key <= '0;
		end else begin
			if (frame.first && frame.cmd == hps_pkg::cmd_kbd) begin
				raw  <= '0;
				skip <= 1'b0;
			end
			if (kbd_word) begin
				if (frame.data[15:8] == hps_pkg::kbd_skip_mark)
					skip <= 1'b1;
				else if (!skip)
					raw <= {raw[23:0], frame.data[7:0]};
			end
			if (frame.done && frame.cmd == hps_pkg::cmd_kbd && !skip) begin
				ps2_key <= {~ps2_key.toggle, pressed, extended, raw[7:0]};
				// print screen and pause do not follow the usual pattern
				if (raw == 32'hE012E07C)
					ps2_key[9:0] <= 10'h37C;
				if (raw == 32'h7CE0F012)
					ps2_key[9:0] <= 10'h17C;
				if (raw == 32'hF014F077)
					ps2_key[9:0] <= 10'h277;
			end
		end
	end

	////////////////////////////////////////
	// byte FIFO and PS/2 transmitter
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (kbd_word)
			fifo_mem[wptr] <= frame.data[7:0];
	end

	// bit clock edges, one per half period
	assign tick = div_cnt == div_w'(ps2_div);
	assign rise = tick && !bit_clk;
	assign fall = tick && bit_clk;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wptr         <= '0;
			rptr         <= '0;
			div_cnt      <= '0;
			bit_clk      <= 1'b0;
			tx_state     <= '0;
			tx_byte      <= '0;
			parity       <= 1'b1;
			idle_cnt     <= '0;
			ps2_kbd_clk  <= 1'b1;
			ps2_kbd_data <= 1'b1;
		end else begin
			if (kbd_word)
				wptr <= wptr + 1'b1;
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				bit_clk <= ~bit_clk;
			if (rise) begin
				ps2_kbd_clk <= 1'b1;
				if (tx_state == 4'd0) begin
					if (wptr != rptr) begin
						idle_cnt <= idle_cnt - 2'd1;
						if (idle_cnt == 2'd0) begin
							tx_byte      <= fifo_mem[rptr];
							rptr         <= rptr + 1'b1;
							parity       <= 1'b1;
							tx_state     <= 4'd1;
							ps2_kbd_data <= 1'b0;
						end
					end
				end else begin
					// data lsb first, then odd parity and the stop bit
					if (tx_state <= 4'd8) begin
						ps2_kbd_data <= tx_byte[0];
						tx_byte      <= {1'b0, tx_byte[7:1]};
						parity       <= parity ^ tx_byte[0];
					end
					if (tx_state == 4'd9)
						ps2_kbd_data <= parity;
					if (tx_state == 4'd10)
						ps2_kbd_data <= 1'b1;
					tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 4'd1;
				end
			end
			if (fall)
				ps2_kbd_clk <= (tx_state == 4'd0);
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_host_model.svh ====
////////////////////////////////////////
// host model for the bridge testbench
// bus driver tasks, reference decode and compare tasks
////////////////////////////////////////
`ifndef TB_HOST_MODEL_SVH
`define TB_HOST_MODEL_SVH

localparam int bus_timeout = 100;
localparam int ps2_timeout = 400;

////////////////////////////////////////
// reference functions
////////////////////////////////////////

// key event from the last four scan bytes of a frame
function automatic hps_pkg::ps2_key_t key_ref(input logic [31:0] raw, input logic toggle);
	hps_pkg::ps2_key_t k;
	k.toggle   = toggle;
	k.code     = raw[7:0];
	k.pressed  = (raw[15:8] != 8'hF0);
	// a release carries its E0 prefix in front of the F0
	k.extended = k.pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
	case (raw)
		32'hE012E07C: {k.pressed, k.extended, k.code} = {2'b11, 8'h7C};
		32'h7CE0F012: {k.pressed, k.extended, k.code} = {2'b01, 8'h7C};
		32'hF014F077: {k.pressed, k.extended, k.code} = {2'b10, 8'h77};
		default: ;
	endcase
	return k;
endfunction

// word k of the string readback, word 0 is the command itself
function automatic logic [7:0] str_ref(input int k);
	if (k >= 1 && k <= conf_text.len())
		return conf_text[k - 1];
	return 8'h00;
endfunction

function automatic logic [26:0] dl_addr(input int n);
	return wide_mode ? 27'(2 * n) : 27'(n);
endfunction

// narrow mode keeps only the low byte
function automatic logic [15:0] dl_word(input logic [15:0] d);
	return wide_mode ? d : {8'h00, d[7:0]};
endfunction

// bit 0 leaves first: start, data lsb first, odd parity, stop
function automatic logic [10:0] ps2_ref(input logic [7:0] b);
	return {1'b1, ~^b, b, 1'b0};
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp)
		abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_joy(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_status(input string name, input logic [63:0] got,
		input logic [63:0] exp);
	if (got !== exp)
		abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_ioctl(input string name, input hps_pkg::ioctl_t got,
		input hps_pkg::ioctl_t exp);
	if (got !== exp)
		abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_key(input string name, input hps_pkg::ps2_key_t got,
		input hps_pkg::ps2_key_t exp);
	if (got !== exp)
		abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

////////////////////////////////////////
// host bus driver, called on a falling edge
////////////////////////////////////////

task automatic wait_ready();
	int n;
	n = 0;
	while (io_wait) begin
		@(negedge clk_sys);
		n++;
		if (n > bus_timeout)
			abort_run("timeout: io_wait never cleared");
	end
endtask

// one strobed word, then an idle cycle so a write strobe sees its own address
task automatic strobe_word(input logic [15:0] w);
	wait_ready();
	host_in.strobe = 1'b1;
	host_in.din    = w;
	@(negedge clk_sys);
	host_in.strobe = 1'b0;
	@(negedge clk_sys);
endtask

task automatic open_frame(input logic [15:0] cmd);
	host_in.enable = 1'b1;
	strobe_word(cmd);
endtask

task automatic close_frame();
	host_in.enable = 1'b0;
	@(negedge clk_sys);
	@(negedge clk_sys);
endtask

task automatic wait_key(input logic toggle);
	int n;
	n = 0;
	while (ps2_key.toggle !== toggle) begin
		@(negedge clk_sys);
		n++;
		if (n > bus_timeout)
			abort_run("timeout: no key event after a keyboard frame");
	end
endtask

task automatic wait_writes(input int count);
	int n;
	n = 0;
	while (wr_seen < count) begin
		@(negedge clk_sys);
		n++;
		if (n > bus_timeout)
			abort_run("timeout: download writes missing");
	end
endtask

// the timeout restarts with every PS/2 frame received
task automatic wait_ps2_done();
	int n;
	int last;
	n    = 0;
	last = ps2_seen;
	while (ps2_exp.size() != 0) begin
		@(negedge clk_sys);
		n++;
		if (ps2_seen != last) begin
			last = ps2_seen;
			n    = 0;
		end
		if (n > ps2_timeout)
			abort_run("timeout: PS/2 frame never arrived");
	end
endtask

////////////////////////////////////////
// keyboard frames
////////////////////////////////////////

// byte n-1 of seq is sent first, byte 0 is the key code
task automatic key_frame(input logic [31:0] seq, input int n);
	hps_pkg::ps2_key_t exp;
	exp = key_ref(seq, ~key_toggle);
	open_frame(hps_pkg::cmd_kbd);
	for (int i = n - 1; i >= 0; i--) begin
		ps2_exp.push_back(seq[8 * i +: 8]);
		strobe_word({8'h00, seq[8 * i +: 8]});
	end
	close_frame();
	wait_key(exp.toggle);
	check_key("ps2_key", ps2_key, exp);
	key_toggle = exp.toggle;
	key_last   = exp;
endtask

// skip mark gives no key event, all bytes still go out on PS/2
task automatic skip_frame();
	logic [15:0] words [3];
	words = '{16'h0012, {hps_pkg::kbd_skip_mark, 8'h55}, 16'h0033};
	open_frame(hps_pkg::cmd_kbd);
	for (int i = 0; i < 3; i++) begin
		ps2_exp.push_back(words[i][7:0]);
		strobe_word(words[i]);
	end
	close_frame();
	check_key("ps2_key", ps2_key, key_last);
endtask

`endif

// ==== sim/tb_hps_io.sv ====
////////////////////////////////////////
// host I/O bridge testbench
// drives host frames, checks registers, downloads,
// key events and the PS/2 serial stream
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_hps_io;

	localparam bit wide_mode = 1'b1;

	logic                 clk_sys;
	logic                 reset;
	hps_pkg::hps_bus_in_t host_in;
	logic                 ioctl_wait;
	logic [47:0]          conf_str;
	logic [63:0]          status_in;
	logic                 status_set;
	logic [15:0]          io_dout;
	logic                 io_wait;
	logic [1:0]           buttons;
	logic                 forced_scandoubler;
	hps_pkg::joy_bank_t   joystick;
	logic [63:0]          status;
	hps_pkg::ioctl_t      ioctl;
	hps_pkg::ps2_key_t    ps2_key;
	logic                 ps2_kbd_clk;
	logic                 ps2_kbd_data;

	integer               seed       = 32'h5949_4bae;
	string                conf_text  = "CORE;V";
	hps_pkg::ioctl_t      wr_exp [$];
	logic [7:0]           ps2_exp [$];
	int                   wr_seen    = 0;
	int                   ps2_seen   = 0;
	int                   ps2_n      = 0;
	logic [10:0]          ps2_bits;
	logic                 ps2_clk_q  = 1'b1;
	logic                 key_toggle = 1'b0;
	hps_pkg::ps2_key_t    key_last   = '0;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

`include "tb_host_model.svh"

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	hps_io #(
		.str_len   (6),
		.wide      (wide_mode),
		.ps2_div   (3),
		.fifo_bits (4)
	) dut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.host_in            (host_in),
		.ioctl_wait         (ioctl_wait),
		.conf_str           (conf_str),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick           (joystick),
		.status             (status),
		.ioctl              (ioctl),
		.ps2_key            (ps2_key),
		.ps2_kbd_clk        (ps2_kbd_clk),
		.ps2_kbd_data       (ps2_kbd_data)
	);

	////////////////////////////////////////
	// monitors
	////////////////////////////////////////

	// each download write against the next expected entry
	always @(negedge clk_sys) begin
		if (!reset && ioctl.wr) begin
			wr_seen++;
			if (wr_exp.size() == 0)
				abort_run("download write seen with none expected");
			else
				check_ioctl("ioctl", ioctl, wr_exp.pop_front());
		end
	end

	// PS/2 data taken at each falling PS/2 clock, seen on the system clock
	always @(negedge clk_sys) begin
		if (ps2_clk_q && !ps2_kbd_clk) begin
			ps2_bits[ps2_n] = ps2_kbd_data;
			ps2_n++;
			if (ps2_n == 11) begin
				ps2_n = 0;
				ps2_seen++;
				if (ps2_exp.size() == 0)
					abort_run("PS/2 frame sent with no byte pushed");
				else
					check_word("ps2 frame", {5'h0, ps2_bits},
						{5'h0, ps2_ref(ps2_exp.pop_front())});
			end
		end
		ps2_clk_q = ps2_kbd_clk;
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin
		logic [15:0]     joy_cmd [6];
		logic [31:0]     joy_exp [6];
		logic [7:0]      cfg_byte;
		logic [63:0]     val64;
		hps_pkg::ioctl_t io_exp;

		host_in    = '0;
		ioctl_wait = 1'b0;
		conf_str   = "CORE;V";
		status_in  = '0;
		status_set = 1'b0;
		reset      = 1'b1;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_word("io_dout", io_dout, 16'h0000);
		check_word("ioctl wr/download", {14'h0, ioctl.wr, ioctl.download}, 16'h0000);
		check_word("ps2 clk/data", {14'h0, ps2_kbd_clk, ps2_kbd_data}, 16'h0003);
		check_key("ps2_key", ps2_key, '0);

		// joysticks, low half in word 1
		joy_cmd = '{hps_pkg::cmd_joy0, hps_pkg::cmd_joy1, hps_pkg::cmd_joy2,
			hps_pkg::cmd_joy3, hps_pkg::cmd_joy4, hps_pkg::cmd_joy5};
		for (int i = 0; i < 6; i++) begin
			joy_exp[i] = $random(seed);
			open_frame(joy_cmd[i]);
			strobe_word(joy_exp[i][15:0]);
			strobe_word(joy_exp[i][31:16]);
			close_frame();
		end
		for (int i = 0; i < 6; i++)
			check_joy($sformatf("joystick[%0d]", i), joystick[i], joy_exp[i]);

		cfg_byte = 8'($random(seed));
		open_frame(hps_pkg::cmd_cfg);
		strobe_word({8'h00, cfg_byte});
		close_frame();
		check_word("buttons/forced_scandoubler", {13'h0, forced_scandoubler, buttons},
			{13'h0, cfg_byte[4], cfg_byte[1:0]});

		// status write, then two set requests and the readback
		val64 = {$random(seed), $random(seed)};
		open_frame(hps_pkg::cmd_status);
		for (int i = 0; i < 4; i++)
			strobe_word(val64[16 * i +: 16]);
		close_frame();
		check_status("status", status, val64);
		for (int i = 0; i < 2; i++) begin
			status_in  = {$random(seed), $random(seed)};
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
			@(negedge clk_sys);
		end
		open_frame(hps_pkg::cmd_status_get);
		check_word("io_dout status_get", io_dout, 16'h00A2);
		for (int i = 0; i < 4; i++) begin
			strobe_word(16'h0000);
			check_word($sformatf("io_dout status word %0d", i + 1), io_dout,
				status_in[16 * i +: 16]);
		end
		close_frame();
		check_word("io_dout after frame", io_dout, 16'h0000);

		open_frame(hps_pkg::cmd_conf_str);
		for (int k = 1; k <= 7; k++) begin
			strobe_word(16'h0000);
			check_word($sformatf("io_dout conf word %0d", k), io_dout, {8'h00, str_ref(k)});
		end
		close_frame();

		// file download
		io_exp.download = 1'b1;
		io_exp.wr       = 1'b1;
		io_exp.index    = 8'($random(seed));
		io_exp.file_ext = $random(seed);
		open_frame(hps_pkg::cmd_file_index);
		strobe_word({8'h00, io_exp.index});
		close_frame();
		open_frame(hps_pkg::cmd_file_info);
		strobe_word(io_exp.file_ext[31:16]);
		strobe_word(io_exp.file_ext[15:0]);
		close_frame();
		open_frame(hps_pkg::cmd_file_tx);
		strobe_word(16'h00FF);
		close_frame();
		check_word("ioctl.download", {15'h0, ioctl.download}, 16'h0001);

		// core back-pressure holds the host off until it clears
		ioctl_wait = 1'b1;
		@(negedge clk_sys);
		check_word("io_wait", {15'h0, io_wait}, 16'h0001);
		fork
			begin
				repeat (4) @(negedge clk_sys);
				ioctl_wait = 1'b0;
			end
		join_none
		open_frame(hps_pkg::cmd_file_tx_dat);
		check_word("io_wait", {15'h0, io_wait}, 16'h0000);
		for (int n = 0; n < 8; n++) begin
			val64[15:0]  = 16'($random(seed));
			io_exp.addr  = dl_addr(n);
			io_exp.dout  = dl_word(val64[15:0]);
			wr_exp.push_back(io_exp);
			strobe_word(val64[15:0]);
		end
		close_frame();
		wait_writes(8);
		open_frame(hps_pkg::cmd_file_tx);
		strobe_word(16'h0000);
		close_frame();
		io_exp.download = 1'b0;
		io_exp.wr       = 1'b0;
		io_exp.addr     = dl_addr(8);
		check_ioctl("ioctl", ioctl, io_exp);

		// key events, then the serial stream of every byte sent
		key_frame(32'h0000001C, 1);
		key_frame(32'h0000F01C, 2);
		key_frame(32'h0000E075, 2);
		key_frame(32'h00E0F075, 3);
		key_frame(32'hE012E07C, 4);
		skip_frame();
		wait_ps2_done();

		// pause and print screen release, sent once the FIFO has drained
		key_frame(32'hF014F077, 4);
		key_frame(32'h7CE0F012, 4);
		wait_ps2_done();

		if (wr_exp.size() != 0 || ps2_exp.size() != 0)
			abort_run("expected events still pending at the end of the run");
		else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
